//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wts_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := wts_defs.svh wts_pkg.sv wts_wave_sequencer.sv wts_wave_ram.sv \
	wts_channel_mixer.sv wts_core.sv tb_wts_core.sv
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+.
wts_pkg.sv
wts_wave_sequencer.sv
wts_wave_ram.sv
wts_channel_mixer.sv
wts_core.sv
tb_wts_core.sv

//--- tb_wts_core.sv
/*
 * Testbench for the wave table sound mixer. Drives random stimulus from a
 * fixed seed and checks the RAM port and the mixed outputs against a model.
 */
`timescale 1ns/1ns
`include "wts_defs.svh"

module tb_wts_core
	import wts_pkg::*;
();

	// Frames per test: reset, RAM port, mix, silence, ramp
	localparam int RUN_FRAMES = 2 + 32 + 290 + 12 + 190;

	logic                                        clk = 1'b0;
	logic                                        nreset;
	logic [`WTS_CHANNELS-1:0]                    key_on;
	logic [`WTS_CHANNELS-1:0][`WTS_FREQ_W-1:0]   frequency_count;
	logic [`WTS_CHANNELS-1:0][`WTS_VOLUME_W-1:0] volume;
	pan_t [`WTS_CHANNELS-1:0]                    pan;
	slot_t                                       sram_id;
	logic [`WTS_WAVE_AW-1:0]                     sram_a;
	logic [`WTS_SAMPLE_W-1:0]                    sram_d;
	logic                                        sram_we;
	logic                                        sram_oe;
	logic [`WTS_SAMPLE_W-1:0]                    sram_q;
	logic                                        sram_q_en;
	logic [`WTS_OUT_W-1:0]                       left_out;
	logic [`WTS_OUT_W-1:0]                       right_out;

	int seed = 25;
	int checks = 0;
	int errors = 0;
	int base_checks = 0;
	int base_errors = 0;
	int q_en_count = 0;
	logic [`WTS_SAMPLE_W-1:0] model_mem [192];
	int chan_value [`WTS_CHANNELS];

	wts_core wts_core_inst (.*);

	always #4 clk = ~clk;

	always @(negedge clk) begin
		if (sram_q_en)
			q_en_count++;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_cond(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s done, %0d checks, %0d errors", name, checks - base_checks,
			errors - base_errors);
		base_checks = checks;
		base_errors = errors;
	endtask

	task automatic wait_frames(input int n);
		repeat (6 * n) @(negedge clk);
	endtask

	// A strobe is one cycle, then the port is left idle for the service window
	task automatic cpu_write(input int id, input int a, input logic [7:0] d);
		@(negedge clk);
		sram_id = slot_t'(3'(id));
		sram_a  = 5'(a);
		sram_d  = d;
		sram_we = 1'b1;
		model_mem[id * 32 + a] = d;
		@(negedge clk);
		sram_we = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	task automatic cpu_read_check(input int id, input int a);
		int pulses;
		logic [7:0] q;
		pulses = 0;
		q = 8'h00;
		@(negedge clk);
		sram_id = slot_t'(3'(id));
		sram_a  = 5'(a);
		sram_oe = 1'b1;
		repeat (7) begin
			@(negedge clk);
			sram_oe = 1'b0;
			if (sram_q_en) begin
				pulses++;
				q = sram_q;
			end
		end
		check_value("ram read", int'(model_mem[id * 32 + a]), int'(q));
		check_cond(pulses == 1, "sram_q_en did not pulse exactly once after a read");
	endtask

	// floor(sample * volume / 16), integer division truncates toward zero
	function automatic int scaled_term(input int s, input int v);
		int p;
		p = s * v;
		if (p < 0 && p % 16 != 0)
			return p / 16 - 1;
		return p / 16;
	endfunction

	// Side 1 is left and side 0 is right, as in the pan encoding
	function automatic int model_out(input int side);
		int sum;
		sum = 2048;
		for (int c = 0; c < `WTS_CHANNELS; c++) begin
			if (pan[c][side])
				sum += scaled_term(chan_value[c], int'(volume[c]));
		end
		return sum & 32'hfff;
	endfunction

	initial begin
		#(RUN_FRAMES * 48 + 2000);
		$display("watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		logic [7:0] d;
		int wr_id [12];
		int wr_a [12];
		int ch;
		int n;
		int prev;
		int cyc;
		int last_change;
		int changes;

		nreset  = 1'b0;
		key_on  = '0;
		frequency_count = '0;
		volume  = '0;
		sram_id = SLOT_A;
		sram_a  = '0;
		sram_d  = '0;
		sram_we = 1'b0;
		sram_oe = 1'b0;
		for (int c = 0; c < `WTS_CHANNELS; c++)
			pan[c] = PAN_OFF;
		repeat (4) @(negedge clk);
		nreset = 1'b1;

		// The first frame is published only after six slots
		repeat (5) begin
			@(negedge clk);
			check_value("reset left_out", 32'h800, int'(left_out));
			check_value("reset right_out", 32'h800, int'(right_out));
			check_value("reset sram_q_en", 0, int'(sram_q_en));
		end
		end_test("reset");

		for (int i = 0; i < 12; i++) begin
			wr_id[i] = $unsigned($random(seed)) % 6;
			wr_a[i]  = $unsigned($random(seed)) % 32;
			cpu_write(wr_id[i], wr_a[i], 8'($random(seed)));
		end
		check_value("q_en before first read", 0, q_en_count);
		for (int i = 0; i < 12; i++) begin
			n = $unsigned($random(seed)) % 12;
			cpu_read_check(wr_id[n], wr_a[n]);
		end
		end_test("ram port");

		for (int c = 0; c < `WTS_CHANNELS; c++) begin
			d = 8'($random(seed));
			chan_value[c] = int'($signed(d));
			for (int a = 0; a < 32; a++)
				cpu_write(c, a, d);
		end
		repeat (4) begin
			for (int c = 0; c < `WTS_CHANNELS; c++) begin
				volume[c] = 4'($random(seed));
				pan[c]    = pan_t'(2'($random(seed)));
			end
			wait_frames(3);
			repeat (3) begin
				check_value("mix left_out", model_out(1), int'(left_out));
				check_value("mix right_out", model_out(0), int'(right_out));
				wait_frames(1);
			end
		end
		end_test("mix");

		volume = '0;
		wait_frames(3);
		check_value("zero volume left_out", 32'h800, int'(left_out));
		check_value("zero volume right_out", 32'h800, int'(right_out));
		for (int c = 0; c < `WTS_CHANNELS; c++) begin
			volume[c] = 4'($random(seed));
			pan[c]    = PAN_OFF;
		end
		wait_frames(3);
		check_value("pan off left_out", 32'h800, int'(left_out));
		check_value("pan off right_out", 32'h800, int'(right_out));
		end_test("silence");

		ch = $unsigned($random(seed)) % 6;
		n  = $unsigned($random(seed)) % 4;
		volume = '0;
		pan[ch] = PAN_LEFT;
		for (int a = 0; a < 32; a++)
			cpu_write(ch, a, 8'(4 * a + 2));
		@(negedge clk);
		frequency_count[ch] = 12'(n);
		key_on[ch] = 1'b1;
		@(negedge clk);
		key_on = '0;
		// Volume comes one cycle late so the sample read before key_on stays muted
		@(negedge clk);
		volume[ch] = 4'd15;
		prev = int'(left_out);
		cyc = 0;
		last_change = 0;
		changes = 0;
		while (changes < 34 && cyc < 36 * (n + 1) * 6) begin
			@(negedge clk);
			cyc++;
			if (int'(left_out) != prev) begin
				check_value("ramp value", scaled_term(4 * (changes % 32) + 2, 15) + 2048,
					int'(left_out));
				if (changes >= 2)
					check_value("ramp step cycles", (n + 1) * 6, cyc - last_change);
				prev = int'(left_out);
				last_change = cyc;
				changes++;
			end
		end
		check_cond(changes == 34, "left_out stopped stepping through the ramp");
		end_test("ramp");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- wts_channel_mixer.sv
/*
 * Channel mixer. Scales each slot's sample by its volume, routes it by pan
 * and sums one frame of six slots into 12-bit offset-binary outputs.
 */
`timescale 1ns/1ns
`include "wts_defs.svh"

module wts_channel_mixer
	import wts_pkg::*;
(
	input  logic                                        clk,
	input  logic                                        nreset,
	input  logic signed [`WTS_SAMPLE_W-1:0]             sample,
	input  slot_t                                       sample_slot,
	input  logic [`WTS_CHANNELS-1:0][`WTS_VOLUME_W-1:0] volume,
	input  pan_t [`WTS_CHANNELS-1:0]                    pan,
	output logic [`WTS_OUT_W-1:0]                       left_out,
	output logic [`WTS_OUT_W-1:0]                       right_out
);

	localparam int PROD_W = `WTS_SAMPLE_W + `WTS_VOLUME_W + 1;
	localparam int TERM_W = `WTS_SAMPLE_W + 1;

	logic [`WTS_VOLUME_W-1:0]       vol_sel;
	pan_t                           pan_sel;
	logic signed [PROD_W-1:0]       product;
	logic signed [TERM_W-1:0]       term;
	logic signed [`WTS_OUT_W-1:0]   term_wide;
	logic signed [`WTS_OUT_W-1:0]   left_term;
	logic signed [`WTS_OUT_W-1:0]   right_term;
	logic signed [`WTS_OUT_W-1:0]   left_acc;
	logic signed [`WTS_OUT_W-1:0]   right_acc;
	logic signed [`WTS_OUT_W-1:0]   left_sum;
	logic signed [`WTS_OUT_W-1:0]   right_sum;

	// ------------------------------------------------------------------
	// Volume scaling and panning
	// ------------------------------------------------------------------
	assign vol_sel = volume[sample_slot];
	assign pan_sel = pan[sample_slot];

	// Volume is unsigned, so it gets a zero sign bit before the multiply
	assign product = sample * $signed({1'b0, vol_sel});

	// Dropping the low 4 bits of a signed product is floor(x / 16)
	assign term      = product[PROD_W-1:`WTS_VOLUME_W];
	assign term_wide = {{(`WTS_OUT_W - TERM_W){term[TERM_W-1]}}, term};

	assign left_term  = pan_sel[1] ? term_wide : '0;
	assign right_term = pan_sel[0] ? term_wide : '0;

	assign left_sum  = left_acc + left_term;
	assign right_sum = right_acc + right_term;

	// ------------------------------------------------------------------
	// Frame accumulation
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_acc  <= '0;
			right_acc <= '0;
		end else if (sample_slot == SLOT_F) begin
			left_acc  <= '0;
			right_acc <= '0;
		end else begin
			left_acc  <= left_sum;
			right_acc <= right_sum;
		end
	end

	// Offset binary is the two's complement sum with its top bit flipped
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_out  <= 12'h800;
			right_out <= 12'h800;
		end else if (sample_slot == SLOT_F) begin
			left_out  <= {~left_sum[`WTS_OUT_W-1], left_sum[`WTS_OUT_W-2:0]};
			right_out <= {~right_sum[`WTS_OUT_W-1], right_sum[`WTS_OUT_W-2:0]};
		end
	end

endmodule

//--- wts_core.sv
/*
 * Top level of the wave table sound mixer. The sequencer feeds the wave RAM,
 * whose registered samples feed the mixer. The CPU reaches the RAM directly.
 */
`timescale 1ns/1ns
`include "wts_defs.svh"

module wts_core
	import wts_pkg::*;
(
	input  logic                                        clk,
	input  logic                                        nreset,
	input  logic [`WTS_CHANNELS-1:0]                    key_on,
	input  logic [`WTS_CHANNELS-1:0][`WTS_FREQ_W-1:0]   frequency_count,
	input  logic [`WTS_CHANNELS-1:0][`WTS_VOLUME_W-1:0] volume,
	input  pan_t [`WTS_CHANNELS-1:0]                    pan,
	input  slot_t                                       sram_id,
	input  logic [`WTS_WAVE_AW-1:0]                     sram_a,
	input  logic [`WTS_SAMPLE_W-1:0]                    sram_d,
	input  logic                                        sram_we,
	input  logic                                        sram_oe,
	output logic [`WTS_SAMPLE_W-1:0]                    sram_q,
	output logic                                        sram_q_en,
	output logic [`WTS_OUT_W-1:0]                       left_out,
	output logic [`WTS_OUT_W-1:0]                       right_out
);

	slot_t                              slot;
	logic [`WTS_WAVE_AW-1:0]            wave_index;
	logic signed [`WTS_SAMPLE_W-1:0]    sample;
	slot_t                              sample_slot;

	wts_wave_sequencer wave_sequencer_inst (
		.clk             (clk),
		.nreset          (nreset),
		.key_on          (key_on),
		.frequency_count (frequency_count),
		.slot            (slot),
		.wave_index      (wave_index)
	);

	wts_wave_ram wave_ram_inst (
		.clk         (clk),
		.nreset      (nreset),
		.slot        (slot),
		.wave_index  (wave_index),
		.sram_id     (sram_id),
		.sram_a      (sram_a),
		.sram_d      (sram_d),
		.sram_we     (sram_we),
		.sram_oe     (sram_oe),
		.sram_q      (sram_q),
		.sram_q_en   (sram_q_en),
		.sample      (sample),
		.sample_slot (sample_slot)
	);

	wts_channel_mixer channel_mixer_inst (
		.clk         (clk),
		.nreset      (nreset),
		.sample      (sample),
		.sample_slot (sample_slot),
		.volume      (volume),
		.pan         (pan),
		.left_out    (left_out),
		.right_out   (right_out)
	);

endmodule

//--- wts_defs.svh
/*
 * Widths and counts shared by the wave table sound mixer.
 * Included by the package and by every RTL module that sizes a port.
 */
`ifndef WTS_DEFS_SVH
`define WTS_DEFS_SVH

// Channels and slots are the same thing here, one slot per channel
`define WTS_CHANNELS    6
`define WTS_SAMPLE_W    8

// 32 samples per channel, RAM address is {channel, wave index}
`define WTS_WAVE_AW     5
`define WTS_RAM_AW      8

`define WTS_VOLUME_W    4
`define WTS_FREQ_W      12
`define WTS_OUT_W       12

`endif

//--- wts_pkg.sv
/*
 * Types shared by the wave table sound mixer.
 * Modules take them with a wildcard import in their header.
 */
`include "wts_defs.svh"

package wts_pkg;

	// Rotating slot, also used as the channel id on every port
	typedef enum logic [$clog2(`WTS_CHANNELS)-1:0] {
		SLOT_A = 3'd0,
		SLOT_B = 3'd1,
		SLOT_C = 3'd2,
		SLOT_D = 3'd3,
		SLOT_E = 3'd4,
		SLOT_F = 3'd5
	} slot_t;

	// High bit feeds the left bus, low bit feeds the right bus
	typedef enum logic [1:0] {
		PAN_OFF   = 2'b00,
		PAN_RIGHT = 2'b01,
		PAN_LEFT  = 2'b10,
		PAN_BOTH  = 2'b11
	} pan_t;

endpackage

//--- wts_wave_ram.sv
/*
 * Shared wave RAM, 32 signed samples per channel. Playback reads every cycle;
 * a CPU request is held until the rotating slot reaches its channel.
 */
`timescale 1ns/1ns
`include "wts_defs.svh"

module wts_wave_ram
	import wts_pkg::*;
(
	input  logic                        clk,
	input  logic                        nreset,
	input  slot_t                       slot,
	input  logic [`WTS_WAVE_AW-1:0]     wave_index,
	input  slot_t                       sram_id,
	input  logic [`WTS_WAVE_AW-1:0]     sram_a,
	input  logic [`WTS_SAMPLE_W-1:0]    sram_d,
	input  logic                        sram_we,
	input  logic                        sram_oe,
	output logic [`WTS_SAMPLE_W-1:0]    sram_q,
	output logic                        sram_q_en,
	output logic signed [`WTS_SAMPLE_W-1:0] sample,
	output slot_t                       sample_slot
);

	localparam int DEPTH = `WTS_CHANNELS * (1 << `WTS_WAVE_AW);

	logic [`WTS_SAMPLE_W-1:0] wave_mem [DEPTH];

	logic                     req_we;
	logic                     req_oe;
	slot_t                    req_id;
	logic [`WTS_WAVE_AW-1:0]  req_a;
	logic [`WTS_SAMPLE_W-1:0] req_d;
	logic                     req_done;
	logic [`WTS_RAM_AW-1:0]   cpu_addr;
	logic [`WTS_RAM_AW-1:0]   play_addr;

	// ------------------------------------------------------------------
	// CPU request latch
	// ------------------------------------------------------------------
	// A fresh strobe wins over completion and replaces a pending request
	always_ff @(posedge clk) begin
		if (!nreset) begin
			req_we <= 1'b0;
			req_oe <= 1'b0;
			req_id <= SLOT_A;
		end else if (sram_we || sram_oe) begin
			req_we <= sram_we;
			req_oe <= sram_oe;
			req_id <= sram_id;
		end else if (req_done) begin
			req_we <= 1'b0;
			req_oe <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sram_we || sram_oe) begin
			req_a <= sram_a;
			req_d <= sram_d;
		end
	end

	assign req_done  = (req_we || req_oe) && (slot == req_id);
	assign cpu_addr  = {req_id, req_a};
	assign play_addr = {slot, wave_index};

	// ------------------------------------------------------------------
	// Array access
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (req_done && req_we) begin
			wave_mem[cpu_addr] <= req_d;
		end
		if (req_done && req_oe) begin
			sram_q <= wave_mem[cpu_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_q_en <= 1'b0;
		end else begin
			sram_q_en <= req_done && req_oe;
		end
	end

	// Sample and its slot leave together, one cycle behind the sequencer
	always_ff @(posedge clk) begin
		if (!nreset) begin
			sample      <= '0;
			sample_slot <= SLOT_A;
		end else begin
			sample      <= wave_mem[play_addr];
			sample_slot <= slot;
		end
	end

	q_en_single_pulse: assert property (
		@(posedge clk) disable iff (!nreset)
		sram_q_en |=> !sram_q_en
	) else $error("sram_q_en high for two cycles");

	no_we_oe_together: assert property (
		@(posedge clk) disable iff (!nreset)
		!(sram_we && sram_oe)
	) else $error("sram_we and sram_oe strobed together");

endmodule

//--- wts_wave_sequencer.sv
/*
 * Slot sequencer. Visits one channel per clock and steps that channel's
 * wave index once every frequency_count+1 visits. key_on restarts a channel.
 */
`timescale 1ns/1ns
`include "wts_defs.svh"

module wts_wave_sequencer
	import wts_pkg::*;
(
	input  logic                                        clk,
	input  logic                                        nreset,
	input  logic [`WTS_CHANNELS-1:0]                    key_on,
	input  logic [`WTS_CHANNELS-1:0][`WTS_FREQ_W-1:0]   frequency_count,
	output slot_t                                       slot,
	output logic [`WTS_WAVE_AW-1:0]                     wave_index
);

	logic [`WTS_FREQ_W-1:0]  divider [`WTS_CHANNELS];
	logic [`WTS_WAVE_AW-1:0] index [`WTS_CHANNELS];

	// ------------------------------------------------------------------
	// Slot rotation A .. F, one slot per cycle
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot <= SLOT_A;
		end else if (slot == SLOT_F) begin
			slot <= SLOT_A;
		end else begin
			slot <= slot_t'(slot + 3'd1);
		end
	end

	// ------------------------------------------------------------------
	// Per channel divider and wave index
	// ------------------------------------------------------------------
	// A channel only advances on its own visit, so one visit is one frame
	always_ff @(posedge clk) begin
		for (int ch = 0; ch < `WTS_CHANNELS; ch++) begin
			if (!nreset || key_on[ch]) begin
				divider[ch] <= '0;
				index[ch]   <= '0;
			end else if (slot == slot_t'(ch)) begin
				if (divider[ch] == frequency_count[ch]) begin
					divider[ch] <= '0;
					// Wraps at 32 by width
					index[ch]   <= index[ch] + 1'b1;
				end else begin
					divider[ch] <= divider[ch] + 1'b1;
				end
			end
		end
	end

	// Index of the visited channel, before this visit's update
	assign wave_index = index[slot];

	// The RAM and the mixer both index 6-entry tables with the slot
	slot_in_range: assert property (
		@(posedge clk) disable iff (!nreset)
		slot inside {[SLOT_A:SLOT_F]}
	) else $error("slot left the range A to F");

endmodule
